// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f tb.f --top-module spdif_tx_tb -o spdif_tx_sim
output=$(./obj_dir/spdif_tx_sim)
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1

// ==== source/bmc_encoder.sv ====
/*
 * Biphase-mark sub-frame serializer: preamble choice, block count, stream start and stop.
 */
`timescale 1ns/1ps
`include "spdif_defines.svh"

module bmc_encoder (
    input  logic                       byte_clk_i,
    input  logic                       reset_i,
    input  spdif_pkg::subframe_word_u  word_i,
    input  logic                       word_valid_i,
    output logic                       word_take_o,
    output logic                       streaming_o,
    output logic                       spdif_o
);

    import spdif_pkg::*;

    // FSM states.
    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_PREAMBLE = 2'd1;
    localparam logic [1:0] ST_AUDIO    = 2'd2;
    localparam logic [1:0] ST_CONTROL  = 2'd3;

    // Last cell of each region: 8 preamble, 48 audio, 8 control cells.
    localparam logic [5:0] PRE_LAST   = 6'd7;
    localparam logic [5:0] AUDIO_LAST = 6'd55;
    localparam logic [5:0] CELL_LAST  = 6'(`SPDIF_SUBFRAME_CELLS - 1);
    localparam logic [8:0] BLOCK_LAST = 9'(`SPDIF_BLOCK_SUBFRAMES - 1);

    subframe_word_u tx_word;
    logic [1:0]     state;
    logic [5:0]     cell_cnt;
    logic [5:0]     next_cell;
    logic [8:0]     sub_cnt;
    logic           first_chan;
    logic [7:0]     preamble;
    logic [7:0]     pattern;
    logic [4:0]     bit_sel;
    logic           data_level;

    // Take a word when idle or in the final cell of a sub-frame.
    assign word_take_o = word_valid_i &&
                         ((state == ST_IDLE) ||
                          (state == ST_CONTROL && cell_cnt == CELL_LAST));

    // Preamble for the next sub-frame, high-line version.
    always_comb begin
        if (sub_cnt == BLOCK_LAST) begin
            pattern = `SPDIF_PREAMBLE_B;
        end else if (first_chan) begin
            pattern = `SPDIF_PREAMBLE_M;
        end else begin
            pattern = `SPDIF_PREAMBLE_W;
        end
    end

    // Level of the next data cell.
    always_comb begin
        next_cell = cell_cnt + 6'd1;
        // Control bits run from word bit 7 down to 4, audio from bit 8 up.
        if (&next_cell[5:3]) begin
            bit_sel = {3'b001, ~next_cell[2:1]};
        end else begin
            bit_sel = next_cell[5:1] + 5'd4;
        end
        // First cell of a bit always toggles; second toggles for a 1.
        data_level = next_cell[0] ? (spdif_o ^ tx_word.raw[bit_sel]) : ~spdif_o;
    end

    // ========================================
    // Cell sequencer
    // ========================================
    always_ff @(posedge byte_clk_i or posedge reset_i) begin
        if (reset_i) begin
            state       <= ST_IDLE;
            cell_cnt    <= 6'd0;
            sub_cnt     <= BLOCK_LAST;
            first_chan  <= 1'b0;
            streaming_o <= 1'b0;
            spdif_o     <= 1'b1;
        end else if (word_take_o) begin
            // First preamble cell is always the inverted line.
            spdif_o     <= ~spdif_o;
            cell_cnt    <= 6'd0;
            state       <= ST_PREAMBLE;
            streaming_o <= 1'b1;
            if (sub_cnt == BLOCK_LAST) begin
                sub_cnt    <= 9'd0;
                first_chan <= 1'b0;
            end else begin
                sub_cnt    <= sub_cnt + 9'd1;
                first_chan <= ~first_chan;
            end
        end else begin
            case (state)
                ST_IDLE: begin
                    cell_cnt <= 6'd0;
                end
                ST_PREAMBLE: begin
                    cell_cnt <= next_cell;
                    if (cell_cnt == PRE_LAST) begin
                        spdif_o <= data_level;
                        state   <= ST_AUDIO;
                    end else begin
                        spdif_o <= preamble[~next_cell[2:0]];
                    end
                end
                ST_AUDIO: begin
                    cell_cnt <= next_cell;
                    spdif_o  <= data_level;
                    if (cell_cnt == AUDIO_LAST) begin
                        state <= ST_CONTROL;
                    end
                end
                ST_CONTROL: begin
                    if (cell_cnt == CELL_LAST) begin
                        // Nothing ready. Line holds and the next stream starts with B.
                        state       <= ST_IDLE;
                        streaming_o <= 1'b0;
                        sub_cnt     <= BLOCK_LAST;
                    end else begin
                        cell_cnt <= next_cell;
                        spdif_o  <= data_level;
                    end
                end
            endcase
        end
    end

    // Word and preamble for the sub-frame being sent.
    always_ff @(posedge byte_clk_i) begin
        if (word_take_o) begin
            tx_word  <= word_i;
            preamble <= spdif_o ? pattern : ~pattern;
        end
    end

endmodule

// ==== source/byte_fifo.sv ====
/*
 * Synchronous show-ahead byte FIFO with registered empty, full and almost-full flags.
 */
`timescale 1ns/1ps
`include "spdif_defines.svh"

module byte_fifo #(
    parameter int DEPTH = `SPDIF_FIFO_DEPTH
) (
    input  logic                     byte_clk_i,
    input  logic                     reset_i,
    input  logic                     wr_en_i,
    input  logic [`SPDIF_BYTE_W-1:0] wr_data_i,
    input  logic                     rd_en_i,
    output logic [`SPDIF_BYTE_W-1:0] rd_data_o,
    output logic                     rd_empty_o,
    output logic                     wr_full_o,
    output logic                     wr_afull_o
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    logic [`SPDIF_BYTE_W-1:0] mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [CW-1:0] count_next;
    logic          do_wr;
    logic          do_rd;

    // Writes into a full FIFO are dropped.
    assign do_wr = wr_en_i && !wr_full_o;
    assign do_rd = rd_en_i && !rd_empty_o;

    // Head of the queue is always visible.
    assign rd_data_o = mem[rd_ptr];

    // Occupancy after this edge.
    always_comb begin
        count_next = count;
        if (do_wr && !do_rd) begin
            count_next = count + CW'(1);
        end else if (do_rd && !do_wr) begin
            count_next = count - CW'(1);
        end
    end

    // ========================================
    // Pointers, count and flags
    // ========================================
    always_ff @(posedge byte_clk_i or posedge reset_i) begin
        if (reset_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            rd_empty_o <= 1'b1;
            wr_full_o  <= 1'b0;
            wr_afull_o <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + AW'(1);
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + AW'(1);
            end
            count      <= count_next;
            // Flags track the new count so they agree with it every cycle.
            rd_empty_o <= (count_next == '0);
            wr_full_o  <= (count_next == CW'(DEPTH));
            wr_afull_o <= (count_next >= CW'(`SPDIF_FIFO_AFULL));
        end
    end

    // Storage array.
    always_ff @(posedge byte_clk_i) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

endmodule

// ==== source/sample_assembler.sv ====
/*
 * Sample assembler: packs FIFO bytes into sub-frame words with even parity.
 * Holds one word under assembly and one finished word for the encoder.
 */
`timescale 1ns/1ps
`include "spdif_defines.svh"

module sample_assembler (
    input  logic                       byte_clk_i,
    input  logic                       reset_i,
    input  logic [1:0]                 bit_depth_i,
    input  logic [`SPDIF_BYTE_W-1:0]   rd_data_i,
    input  logic                       rd_empty_i,
    input  logic                       word_take_i,
    output logic                       rd_en_o,
    output spdif_pkg::subframe_word_u  word_o,
    output logic                       word_valid_o
);

    import spdif_pkg::*;

    subframe_word_u asm_word;
    logic [1:0]     byte_idx;
    logic [1:0]     last_idx;
    logic           asm_done;
    logic           out_free;
    logic           move_out;

    // Index of the final byte of a sample.
    always_comb begin
        case (bit_depth_i)
            `SPDIF_DEPTH_16: last_idx = 2'd1;
            `SPDIF_DEPTH_24: last_idx = 2'd2;
            default:         last_idx = 2'd2;
        endcase
    end

    // Pop while bytes wait and the slot is not holding a finished word.
    assign rd_en_o  = !rd_empty_i && !asm_done;

    // Output register can accept when empty or emptied on this edge.
    assign out_free = !word_valid_o || word_take_i;
    assign move_out = asm_done && out_free;

    // ========================================
    // Control state
    // ========================================
    always_ff @(posedge byte_clk_i or posedge reset_i) begin
        if (reset_i) begin
            byte_idx     <= 2'd0;
            asm_done     <= 1'b0;
            word_valid_o <= 1'b0;
        end else begin
            if (rd_en_o) begin
                if (byte_idx == last_idx) begin
                    byte_idx <= 2'd0;
                    asm_done <= 1'b1;
                end else begin
                    byte_idx <= byte_idx + 2'd1;
                end
            end else if (move_out) begin
                asm_done <= 1'b0;
            end
            // A newly finished word wins over a take on the same edge.
            if (move_out) begin
                word_valid_o <= 1'b1;
            end else if (word_take_i) begin
                word_valid_o <= 1'b0;
            end
        end
    end

    // ========================================
    // Word packing
    // ========================================
    always_ff @(posedge byte_clk_i) begin
        if (rd_en_o) begin
            if (byte_idx == 2'd0) begin
                // First byte clears the rest of the word.
                asm_word.fields.audio          <= {16'h0000, rd_data_i};
                asm_word.fields.validity       <= 1'b0;
                asm_word.fields.user           <= 1'b0;
                asm_word.fields.channel_status <= 1'b0;
                asm_word.fields.parity         <= ^rd_data_i;
                asm_word.fields.pad            <= 4'h0;
            end else begin
                asm_word.fields.audio[{byte_idx, 3'b000} +: `SPDIF_BYTE_W] <= rd_data_i;
                // Running XOR; V, U and C are zero so this is the whole parity.
                asm_word.fields.parity <= asm_word.fields.parity ^ (^rd_data_i);
            end
        end
        if (move_out) begin
            word_o <= asm_word;
        end
    end

endmodule

// ==== source/spdif_defines.svh ====
/*
 * Shared widths, FIFO sizing, bit-depth codes, preamble patterns and frame counts.
 */
`ifndef SPDIF_DEFINES_SVH
`define SPDIF_DEFINES_SVH

// Audio byte width and FIFO sizing.
`define SPDIF_BYTE_W         8
`define SPDIF_FIFO_DEPTH     16
`define SPDIF_FIFO_AFULL     12

// Legal bit_depth_i codes; any other code is handled as 24-bit.
`define SPDIF_DEPTH_16       2'b00
`define SPDIF_DEPTH_24       2'b01

// Preambles, sent MSB first, for a line that is high before them.
// With the line low the complement goes out instead.
`define SPDIF_PREAMBLE_B     8'b00010111
`define SPDIF_PREAMBLE_M     8'b00011101
`define SPDIF_PREAMBLE_W     8'b00011011

// Half-bit cells per sub-frame and sub-frames per block.
`define SPDIF_SUBFRAME_CELLS  64
`define SPDIF_BLOCK_SUBFRAMES 384

`endif

// ==== source/spdif_pkg.sv ====
/*
 * Sub-frame word type shared by the assembler, the encoder and the top level.
 */
package spdif_pkg;

    // ========================================
    // Sub-frame word
    // ========================================
    // The assembler fills the named fields.
    // The serializer walks the same word bit by bit.
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [23:0] audio;           // Sample LSB sits at word bit 8.
            logic        validity;
            logic        user;
            logic        channel_status;
            logic        parity;          // Even parity over bits 4 to 31.
            logic [3:0]  pad;             // Preamble slot, always zero.
        } fields;
    } subframe_word_u;

endpackage

// ==== source/spdif_tx_top.sv ====
/*
 * S/PDIF transmitter top level: byte FIFO, sample assembler and biphase-mark encoder.
 */
`timescale 1ns/1ps
`include "spdif_defines.svh"

module spdif_tx_top (
    input  logic                     byte_clk_i,
    input  logic                     reset_i,
    input  logic [1:0]               bit_depth_i,
    input  logic                     wr_en_i,
    input  logic [`SPDIF_BYTE_W-1:0] wr_data_i,
    output logic                     wr_full_o,
    output logic                     wr_afull_o,
    output logic                     streaming_o,
    output logic                     spdif_o
);

    import spdif_pkg::*;

    logic [`SPDIF_BYTE_W-1:0] rd_data;
    logic                     rd_empty;
    logic                     rd_en;
    subframe_word_u           word;
    logic                     word_valid;
    logic                     word_take;

    // ========================================
    // Byte FIFO
    // ========================================
    byte_fifo #(
        .DEPTH (`SPDIF_FIFO_DEPTH)
    ) i_fifo (
        .byte_clk_i (byte_clk_i),
        .reset_i    (reset_i),
        .wr_en_i    (wr_en_i),
        .wr_data_i  (wr_data_i),
        .rd_en_i    (rd_en),
        .rd_data_o  (rd_data),
        .rd_empty_o (rd_empty),
        .wr_full_o  (wr_full_o),
        .wr_afull_o (wr_afull_o)
    );

    // Packs bytes into sub-frame words.
    sample_assembler i_assembler (
        .byte_clk_i   (byte_clk_i),
        .reset_i      (reset_i),
        .bit_depth_i  (bit_depth_i),
        .rd_data_i    (rd_data),
        .rd_empty_i   (rd_empty),
        .word_take_i  (word_take),
        .rd_en_o      (rd_en),
        .word_o       (word),
        .word_valid_o (word_valid)
    );

    // Serializes words onto the line.
    bmc_encoder i_encoder (
        .byte_clk_i   (byte_clk_i),
        .reset_i      (reset_i),
        .word_i       (word),
        .word_valid_i (word_valid),
        .word_take_o  (word_take),
        .streaming_o  (streaming_o),
        .spdif_o      (spdif_o)
    );

endmodule

// ==== tb.f ====
+incdir+source
source/spdif_pkg.sv
source/byte_fifo.sv
source/sample_assembler.sv
source/bmc_encoder.sv
source/spdif_tx_top.sv
verif/tb_clock_gen.sv
verif/spdif_checker.sv
verif/spdif_tx_tb.sv

// ==== verif/spdif_checker.sv ====
/*
 * S/PDIF line checker: rebuilds expected sub-frame words from accepted writes,
 * decodes spdif_o 64 cells at a time and compares preambles, coding and words.
 */
`timescale 1ns/1ps
`include "spdif_defines.svh"

module spdif_checker (
    input  logic                     byte_clk_i,
    input  logic                     reset_i,
    input  logic [1:0]               bit_depth_i,
    input  logic                     wr_en_i,
    input  logic [`SPDIF_BYTE_W-1:0] wr_data_i,
    input  logic                     wr_full_i,
    input  logic                     wr_afull_i,
    input  logic                     streaming_i,
    input  logic                     spdif_i,
    input  logic [8*11-1:0]          test_name_i,
    output int                       err_count_o,
    output int                       frame_count_o
);

    logic [`SPDIF_BYTE_W-1:0] exp_bytes [$];
    logic [63:0]              cells;
    int                       cell_n;
    int                       sub_idx;
    logic                     start_level;
    logic                     prev_level;
    logic                     was_streaming;
    logic                     reset_seen;

    // ========================================
    // Sub-frame decode and compare
    // ========================================
    task automatic decode_subframe();
        logic [63:0] work;
        logic [7:0]  exp_pre;
        logic [7:0]  got_pre;
        logic [27:0] bits;
        logic [31:0] got_word;
        logic [31:0] exp_word;
        logic [7:0]  b0;
        logic [7:0]  b1;
        logic [7:0]  b2;
        logic        c0;
        logic        c1;
        logic        prev;
        int          need;
        // B opens a block, odd slots carry W, the rest M.
        if ((sub_idx % `SPDIF_BLOCK_SUBFRAMES) == 0) begin
            exp_pre = `SPDIF_PREAMBLE_B;
        end else if ((sub_idx % 2) == 1) begin
            exp_pre = `SPDIF_PREAMBLE_W;
        end else begin
            exp_pre = `SPDIF_PREAMBLE_M;
        end
        // Low line before the preamble flips the pattern.
        if (!start_level) begin
            exp_pre = ~exp_pre;
        end
        work    = cells;
        got_pre = work[63:56];
        if (got_pre != exp_pre) begin
            err_count_o++;
            $display("[FAIL] %s sub-frame %0d preamble: expected %08b, actual %08b",
                     test_name_i, sub_idx, exp_pre, got_pre);
        end
        prev = work[56];
        work = work << 8;
        bits = '0;
        // 28 data bits, two cells each, first bit on the wire lands in bits[0].
        for (int j = 0; j < 28; j++) begin
            c0   = work[63];
            c1   = work[62];
            work = work << 2;
            if (c0 == prev) begin
                err_count_o++;
                $display("%s: sub-frame %0d data bit %0d did not toggle at its first cell",
                         test_name_i, sub_idx, j);
            end
            bits = {c0 ^ c1, bits[27:1]};
            prev = c1;
        end
        // Control bits go out from word bit 7 down to bit 4.
        got_word = {bits[23:0], bits[24], bits[25], bits[26], bits[27], 4'h0};
        if (^got_word[31:4]) begin
            err_count_o++;
            $display("[FAIL] %s sub-frame %0d parity of bits 31:4: expected 0, actual 1",
                     test_name_i, sub_idx);
        end
        need = (bit_depth_i == `SPDIF_DEPTH_16) ? 2 : 3;
        if (exp_bytes.size() < need) begin
            err_count_o++;
            $display("%s: sub-frame %0d was sent with no matching bytes written",
                     test_name_i, sub_idx);
        end else begin
            b0 = exp_bytes.pop_front();
            b1 = exp_bytes.pop_front();
            b2 = (need == 3) ? exp_bytes.pop_front() : 8'h00;
            // V, U and C stay zero, parity makes the ones even.
            exp_word = {b2, b1, b0, 3'b000, ^{b2, b1, b0}, 4'h0};
            if (got_word != exp_word) begin
                err_count_o++;
                $display("[FAIL] %s sub-frame %0d word: expected %08h, actual %08h",
                         test_name_i, sub_idx, exp_word, got_word);
            end
        end
        frame_count_o++;
    endtask

    // ========================================
    // Port monitor, sampled mid-cycle
    // ========================================
    always @(negedge byte_clk_i) begin
        if (reset_i) begin
            err_count_o   = 0;
            frame_count_o = 0;
            cell_n        = 0;
            sub_idx       = 0;
            prev_level    = 1'b1;
            was_streaming = 1'b0;
            reset_seen    = 1'b0;
            exp_bytes.delete();
        end else begin
            // Reset values, once.
            if (!reset_seen) begin
                if (spdif_i !== 1'b1 || streaming_i !== 1'b0 ||
                    wr_full_i !== 1'b0 || wr_afull_i !== 1'b0) begin
                    err_count_o++;
                    $display("[FAIL] reset outputs {spdif,streaming,full,afull}: %s %b, %s %b",
                             "expected", 4'b1000, "actual",
                             {spdif_i, streaming_i, wr_full_i, wr_afull_i});
                end
                reset_seen = 1'b1;
            end
            if (wr_full_i && !wr_afull_i) begin
                err_count_o++;
                $display("%s: wr_full_o is high while wr_afull_o is low", test_name_i);
            end
            // Bytes the FIFO takes on the coming edge.
            if (wr_en_i && !wr_full_i) begin
                exp_bytes.push_back(wr_data_i);
            end
            if (streaming_i) begin
                if (cell_n == 0) begin
                    start_level = prev_level;
                end
                cells  = {cells[62:0], spdif_i};
                cell_n = cell_n + 1;
                if (cell_n == `SPDIF_SUBFRAME_CELLS) begin
                    decode_subframe();
                    cell_n  = 0;
                    sub_idx = sub_idx + 1;
                end
            end else begin
                if (was_streaming && cell_n != 0) begin
                    err_count_o++;
                    $display("%s: stream stopped after %0d cells of a sub-frame",
                             test_name_i, cell_n);
                end
                if (was_streaming) begin
                    cell_n  = 0;
                    sub_idx = 0;
                end
                // Idle line holds.
                if (spdif_i != prev_level) begin
                    err_count_o++;
                    $display("%s: spdif_o changed while the stream was idle", test_name_i);
                end
            end
            was_streaming = streaming_i;
            prev_level    = spdif_i;
        end
    end

endmodule

// ==== verif/spdif_tx_tb.sv ====
/*
 * Testbench top with the test table, byte writer, timeout and final report.
 */
`timescale 1ns/1ps
`include "spdif_defines.svh"

module spdif_tx_tb;

    localparam int NUM_TESTS = 4;

    logic                     byte_clk;
    logic                     reset;
    logic [1:0]               bit_depth;
    logic                     wr_en;
    logic [`SPDIF_BYTE_W-1:0] wr_data;
    logic                     wr_full;
    logic                     wr_afull;
    logic                     streaming;
    logic                     spdif;
    logic [8*11-1:0]          cur_name;
    int                       chk_errors;
    int                       chk_frames;
    int                       tb_errors;
    int                       cycles = 0;
    int                       limit;

    // Test table of name, bit depth, samples and idle gap in cycles.
    logic [8*11-1:0] tbl_name    [NUM_TESTS];
    logic [1:0]      tbl_depth   [NUM_TESTS];
    int              tbl_samples [NUM_TESTS];
    int              tbl_gap     [NUM_TESTS];

    tb_clock_gen i_clock (
        .byte_clk_o (byte_clk),
        .reset_o    (reset)
    );

    spdif_tx_top i_dut (
        .byte_clk_i  (byte_clk),
        .reset_i     (reset),
        .bit_depth_i (bit_depth),
        .wr_en_i     (wr_en),
        .wr_data_i   (wr_data),
        .wr_full_o   (wr_full),
        .wr_afull_o  (wr_afull),
        .streaming_o (streaming),
        .spdif_o     (spdif)
    );

    spdif_checker i_checker (
        .byte_clk_i    (byte_clk),
        .reset_i       (reset),
        .bit_depth_i   (bit_depth),
        .wr_en_i       (wr_en),
        .wr_data_i     (wr_data),
        .wr_full_i     (wr_full),
        .wr_afull_i    (wr_afull),
        .streaming_i   (streaming),
        .spdif_i       (spdif),
        .test_name_i   (cur_name),
        .err_count_o   (chk_errors),
        .frame_count_o (chk_frames)
    );

    // ========================================
    // Timeout
    // ========================================
    always @(posedge byte_clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: no result after %0d cycles", limit);
            $display("Test failed");
            $finish;
        end
    end

    // ========================================
    // Stimulus
    // ========================================
    initial begin
        logic [1:0] idx;
        int         bytes_left;
        int         errs_before;
        int         frames_before;
        int         got;
        int         passed;
        tbl_name[0] = "pcm24_basic";
        tbl_depth[0] = `SPDIF_DEPTH_24;
        tbl_samples[0] = 40;
        tbl_gap[0] = 40;
        tbl_name[1] = "pcm16_basic";
        tbl_depth[1] = `SPDIF_DEPTH_16;
        tbl_samples[1] = 40;
        tbl_gap[1] = 40;
        // Long enough to wrap the 384 sub-frame block.
        tbl_name[2] = "pcm24_block";
        tbl_depth[2] = `SPDIF_DEPTH_24;
        tbl_samples[2] = 400;
        tbl_gap[2] = 60;
        tbl_name[3] = "pcm16_again";
        tbl_depth[3] = `SPDIF_DEPTH_16;
        tbl_samples[3] = 20;
        tbl_gap[3] = 100;
        // Reset time plus, per test, the stream, its gap and some slack.
        limit = 16;
        for (int t = 0; t < NUM_TESTS; t++) begin
            idx   = 2'(t);
            limit = limit + tbl_samples[idx] * `SPDIF_SUBFRAME_CELLS + tbl_gap[idx] + 200;
        end
        void'($urandom(29323));
        bit_depth = `SPDIF_DEPTH_24;
        wr_en     = 1'b0;
        wr_data   = '0;
        cur_name  = tbl_name[0];
        tb_errors = 0;
        passed    = 0;
        @(negedge reset);
        repeat (4) @(posedge byte_clk);
        #2;
        for (int t = 0; t < NUM_TESTS; t++) begin
            idx           = 2'(t);
            cur_name      = tbl_name[idx];
            bit_depth     = tbl_depth[idx];
            errs_before   = chk_errors + tb_errors;
            frames_before = chk_frames;
            bytes_left    = tbl_samples[idx] * ((tbl_depth[idx] == `SPDIF_DEPTH_16) ? 2 : 3);
            // One byte per cycle while the FIFO has room.
            while (bytes_left > 0) begin
                @(posedge byte_clk);
                #2;
                if (!wr_full) begin
                    wr_en      = 1'b1;
                    wr_data    = 8'($urandom());
                    bytes_left = bytes_left - 1;
                end else begin
                    wr_en = 1'b0;
                end
            end
            @(posedge byte_clk);
            #2;
            wr_en = 1'b0;
            // Drain.
            while (!streaming) begin
                @(posedge byte_clk);
                #2;
            end
            while (streaming) begin
                @(posedge byte_clk);
                #2;
            end
            repeat (tbl_gap[idx]) @(posedge byte_clk);
            #2;
            got = chk_frames - frames_before;
            if (got != tbl_samples[idx]) begin
                tb_errors++;
                $display("[FAIL] %s sub-frame count: expected %0d, actual %0d",
                         cur_name, tbl_samples[idx], got);
            end
            if (chk_errors + tb_errors == errs_before) begin
                passed++;
                $display("%s: %0d sub-frames, ok", cur_name, got);
            end else begin
                $display("%s: %0d sub-frames, %0d errors", cur_name, got,
                         chk_errors + tb_errors - errs_before);
            end
        end
        $display("Summary: %0d tests, %0d passed, %0d errors",
                 NUM_TESTS, passed, chk_errors + tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== verif/tb_clock_gen.sv ====
/*
 * Testbench clock and reset source: 20 ns clock, reset high for 16 cycles.
 */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic byte_clk_o,
    output logic reset_o
);

    // Free-running clock, 10 ns per phase.
    initial begin
        byte_clk_o = 1'b0;
        forever #10 byte_clk_o = ~byte_clk_o;
    end

    // Reset released just after the 16th rising edge.
    initial begin
        reset_o = 1'b1;
        repeat (16) @(posedge byte_clk_o);
        #2;
        reset_o = 1'b0;
    end

endmodule
